/* aim_bot.f */
source/aim_bot_pkg.sv
source/cam_byte_pack.sv
source/pixel_fifo.sv
source/pixel_combine.sv
source/valid_tick.sv
source/aim_bot.sv
tb/tb_aim_bot.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the aim_bot testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_aim_bot \
    -f aim_bot.f -o sim_aim_bot > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_aim_bot > sim.log 2>&1 \
    && ! grep -q "TEST FAIL" sim.log \
    && grep -q "TEST PASS" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb/tb_aim_bot.sv */
`default_nettype none

module tb_aim_bot;

    localparam int FIFO_DEPTH = 4;
    localparam int TICK       = 8;
    localparam int MAX_GAP    = 3;
    // Two bytes after the longest gaps, plus the closing idle cycle
    localparam int PIX_CYCLES = 2 * (MAX_GAP + 1) + 1;
    localparam int RUN_CYCLES = 8 + 45 * PIX_CYCLES + 6 * 44 + 100;

    logic        clk;
    logic        rst_n;
    logic [2:1]  href;
    logic [2:1]  strobe;
    logic [2:1]  inited;
    logic [7:0]  data [2:1];
    logic [15:0] pixel_1;
    logic [15:0] pixel_2;
    logic        buf_valid;
    logic        buf_tick;
    logic        cam_inited;
    logic        overflow_1;
    logic        overflow_2;

    logic [15:0] exp_1 [$];
    logic [15:0] exp_2 [$];
    logic [31:0] pair;
    logic        tick_due;
    int          errors;
    int          beats;
    int          ticks;
    int          i;
    string       test_name;

    aim_bot #(.FIFO_DEPTH(FIFO_DEPTH), .TICK(TICK)) u_dut (
        .clk        (clk       ),
        .rst_n      (rst_n     ),
        .cam1_href  (href[1]   ),
        .cam1_strobe(strobe[1] ),
        .cam1_data  (data[1]   ),
        .cam1_inited(inited[1] ),
        .cam2_href  (href[2]   ),
        .cam2_strobe(strobe[2] ),
        .cam2_data  (data[2]   ),
        .cam2_inited(inited[2] ),
        .pixel_1    (pixel_1   ),
        .pixel_2    (pixel_2   ),
        .buf_valid  (buf_valid ),
        .buf_tick   (buf_tick  ),
        .cam_inited (cam_inited),
        .overflow_1 (overflow_1),
        .overflow_2 (overflow_2)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Left and right pixel expected on the next paired beat
    function automatic logic [31:0] expected_pair();
        logic [15:0] left;
        logic [15:0] right;
        left  = exp_1.pop_front();
        right = exp_2.pop_front();
        return {left, right};
    endfunction

    task automatic check_bit(input string what, input logic expected, input logic actual);
        assert (expected === actual) else begin
            errors++;
            $display("[FAIL] %s: %s expected %0b actual %0b", test_name, what, expected, actual);
        end
    endtask

    // One camera cycle, set up on the falling edge
    task automatic drive(input int cam, input logic h, input logic s, input logic [7:0] d);
        @(negedge clk);
        href[cam]   = h;
        strobe[cam] = s;
        data[cam]   = d;
    endtask

    task automatic send_pixel(input int cam, input logic [15:0] pix, input bit keep);
        int gap;
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap) drive(cam, 1'b1, 1'b0, 8'h00);
        drive(cam, 1'b1, 1'b1, pix[15:8]);
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap) drive(cam, 1'b1, 1'b0, 8'h00);
        drive(cam, 1'b1, 1'b1, pix[7:0]);
        drive(cam, 1'b1, 1'b0, 8'h00);
        // Buffered only from a ready camera
        if (keep && inited[cam]) begin
            if (cam == 1) begin
                exp_1.push_back(pix);
            end else begin
                exp_2.push_back(pix);
            end
        end
    endtask

    task automatic send_burst(input int cam, input int n);
        int k;
        for (k = 0; k < n; k++) begin
            send_pixel(cam, 16'($urandom), 1'b1);
        end
        drive(cam, 1'b0, 1'b0, 8'h00);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_1.size() != 0 || exp_2.size() != 0) && n < 40) begin
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
        assert (exp_1.size() == 0 && exp_2.size() == 0) else begin
            errors++;
            $display("%s: pixels left unpaired, %0d from camera 1 and %0d from camera 2",
                     test_name, exp_1.size(), exp_2.size());
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            check_bit("buf_tick", tick_due, buf_tick);
            if (buf_tick) begin
                ticks++;
            end
            tick_due = 1'b0;
            if (buf_valid) begin
                beats++;
                tick_due = (beats % TICK == 0);
                assert (exp_1.size() != 0 && exp_2.size() != 0) else begin
                    errors++;
                    $display("%s: paired beat appeared with no pixel queued", test_name);
                end
                if (exp_1.size() != 0 && exp_2.size() != 0) begin
                    pair = expected_pair();
                    assert (pixel_1 === pair[31:16]) else begin
                        errors++;
                        $display("[FAIL] %s: pixel_1 expected %h actual %h",
                                 test_name, pair[31:16], pixel_1);
                    end
                    assert (pixel_2 === pair[15:0]) else begin
                        errors++;
                        $display("[FAIL] %s: pixel_2 expected %h actual %h",
                                 test_name, pair[15:0], pixel_2);
                    end
                end
            end
        end
    end

    initial begin
        #(RUN_CYCLES * 40);
        errors++;
        $display("Run timed out during %s", test_name);
        $display("Errors: %0d, paired beats: %0d, ticks: %0d", errors, beats, ticks);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        void'($urandom(89));
        errors    = 0;
        beats     = 0;
        ticks     = 0;
        tick_due  = 1'b0;
        test_name = "reset";
        rst_n     = 1'b0;
        href      = 2'b00;
        strobe    = 2'b00;
        inited    = 2'b11;
        data[1]   = 8'h00;
        data[2]   = 8'h00;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        test_name = "pairing";
        fork
            send_burst(1, 12);
            send_burst(2, 12);
        join
        drain();

        // Lone high byte, then the line ends
        test_name = "href_drop";
        drive(1, 1'b1, 1'b1, 8'hA5);
        drive(1, 1'b0, 1'b0, 8'h00);
        fork
            send_burst(1, 3);
            send_burst(2, 3);
        join
        drain();

        test_name = "skew";
        for (i = 0; i < 3; i++) begin
            send_pixel(1, 16'($urandom), 1'b1);
        end
        for (i = 0; i < 5; i++) begin
            fork
                send_pixel(1, 16'($urandom), 1'b1);
                send_pixel(2, 16'($urandom), 1'b1);
            join
        end
        drive(1, 1'b0, 1'b0, 8'h00);
        send_burst(2, 3);
        drain();
        check_bit("overflow_1", 1'b0, overflow_1);
        check_bit("overflow_2", 1'b0, overflow_2);

        test_name = "inited";
        @(negedge clk);
        inited[2] = 1'b0;
        send_burst(2, 3);
        drain();
        // Only the last setting has both cameras ready
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            inited = 2'(i);
            @(posedge clk);
            check_bit("cam_inited", i == 3, cam_inited);
        end
        fork
            send_burst(1, 2);
            send_burst(2, 2);
        join
        drain();

        // Camera 2 idle, so nothing leaves buffer 1
        test_name = "overflow";
        for (i = 0; i < 6; i++) begin
            send_pixel(1, 16'($urandom), i < FIFO_DEPTH);
        end
        drive(1, 1'b0, 1'b0, 8'h00);
        repeat (2) @(negedge clk);
        check_bit("overflow_1", 1'b1, overflow_1);
        send_burst(2, FIFO_DEPTH);
        drain();
        check_bit("overflow_1", 1'b1, overflow_1);
        check_bit("overflow_2", 1'b0, overflow_2);

        test_name = "tick";
        assert (ticks == beats / TICK) else begin
            errors++;
            $display("%0d ticks seen for %0d paired beats", ticks, beats);
        end

        $display("Errors: %0d, paired beats: %0d, ticks: %0d", errors, beats, ticks);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule : tb_aim_bot

`default_nettype wire

/* source/aim_bot.sv */
`default_nettype none

module aim_bot #(
    parameter int FIFO_DEPTH = aim_bot_pkg::FIFO_DEPTH_DEFAULT,
    parameter int TICK       = aim_bot_pkg::TICK_DEFAULT
) (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         cam1_href,
    input  wire                         cam1_strobe,
    input  wire aim_bot_pkg::cam_byte_t cam1_data,
    input  wire                         cam1_inited,

    input  wire                         cam2_href,
    input  wire                         cam2_strobe,
    input  wire aim_bot_pkg::cam_byte_t cam2_data,
    input  wire                         cam2_inited,

    output wire aim_bot_pkg::pixel_t    pixel_1,
    output wire aim_bot_pkg::pixel_t    pixel_2,
    output wire                         buf_valid,
    output wire                         buf_tick,
    output wire                         cam_inited,
    output wire                         overflow_1,
    output wire                         overflow_2
);

    wire                      cam1_href_565;
    wire                      cam2_href_565;
    wire                      cam1_strobe_565;
    wire                      cam2_strobe_565;
    wire aim_bot_pkg::pixel_t cam1_data_565;
    wire aim_bot_pkg::pixel_t cam2_data_565;

    // High once both cameras are ready
    assign cam_inited = cam1_inited && cam2_inited;

    cam_byte_pack u_cam1_pack (
        .clk       (clk            ),
        .rst_n     (rst_n          ),
        .href      (cam1_href      ),
        .strobe    (cam1_strobe    ),
        .data      (cam1_data      ),
        .href_565  (cam1_href_565  ),
        .strobe_565(cam1_strobe_565),
        .data_565  (cam1_data_565  )
    );

    cam_byte_pack u_cam2_pack (
        .clk       (clk            ),
        .rst_n     (rst_n          ),
        .href      (cam2_href      ),
        .strobe    (cam2_strobe    ),
        .data      (cam2_data      ),
        .href_565  (cam2_href_565  ),
        .strobe_565(cam2_strobe_565),
        .data_565  (cam2_data_565  )
    );

    pixel_combine #(.FIFO_DEPTH(FIFO_DEPTH)) u_pixel_combine (
        .clk       (clk            ),
        .rst_n     (rst_n          ),
        // Cam1
        .inited_1  (cam1_inited    ),
        .href_1    (cam1_href_565  ),
        .strobe_1  (cam1_strobe_565),
        .data_1    (cam1_data_565  ),
        // Cam2
        .inited_2  (cam2_inited    ),
        .href_2    (cam2_href_565  ),
        .strobe_2  (cam2_strobe_565),
        .data_2    (cam2_data_565  ),
        .pixel_1   (pixel_1        ),
        .pixel_2   (pixel_2        ),
        .valid     (buf_valid      ),
        .overflow_1(overflow_1     ),
        .overflow_2(overflow_2     )
    );

    valid_tick #(.TICK(TICK)) u_buf_tick (
        .clk  (clk      ),
        .rst_n(rst_n    ),
        .trig (buf_valid),
        .tick (buf_tick )
    );

endmodule : aim_bot

`default_nettype wire

/* source/valid_tick.sv */
`default_nettype none

module valid_tick #(
    parameter int TICK = aim_bot_pkg::TICK_DEFAULT
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  trig,
    output logic tick
);

    localparam int CW = (TICK > 1) ? $clog2(TICK) : 1;
    localparam logic [CW-1:0] LAST = CW'(TICK - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (trig) begin
                if (cnt == LAST) begin
                    // TICK-th beat seen, wrap and pulse
                    cnt  <= '0;
                    tick <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule : valid_tick

`default_nettype wire

/* source/pixel_combine.sv */
`default_nettype none

module pixel_combine #(
    parameter int FIFO_DEPTH = aim_bot_pkg::FIFO_DEPTH_DEFAULT
) (
    input  wire                      clk,
    input  wire                      rst_n,
    // Camera 1
    input  wire                      inited_1,
    input  wire                      href_1,
    input  wire                      strobe_1,
    input  wire aim_bot_pkg::pixel_t data_1,
    // Camera 2
    input  wire                      inited_2,
    input  wire                      href_2,
    input  wire                      strobe_2,
    input  wire aim_bot_pkg::pixel_t data_2,
    output aim_bot_pkg::pixel_t      pixel_1,
    output aim_bot_pkg::pixel_t      pixel_2,
    output logic                     valid,
    output logic                     overflow_1,
    output logic                     overflow_2
);

    aim_bot_pkg::pixel_t head_1;
    aim_bot_pkg::pixel_t head_2;
    logic                wr_1;
    logic                wr_2;
    logic                empty_1;
    logic                empty_2;
    logic                pop;

    // Nothing is buffered from a camera that is not configured yet
    assign wr_1 = strobe_1 && href_1 && inited_1;
    assign wr_2 = strobe_2 && href_2 && inited_2;

    // Both heads leave together, this keeps the streams in step
    assign pop = !empty_1 && !empty_2;

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_1 (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .wr      (wr_1      ),
        .wdata   (data_1    ),
        .rd      (pop       ),
        .rdata   (head_1    ),
        .empty   (empty_1   ),
        .overflow(overflow_1)
    );

    pixel_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo_2 (
        .clk     (clk       ),
        .rst_n   (rst_n     ),
        .wr      (wr_2      ),
        .wdata   (data_2    ),
        .rd      (pop       ),
        .rdata   (head_2    ),
        .empty   (empty_2   ),
        .overflow(overflow_2)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid   <= 1'b0;
            pixel_1 <= '0;
            pixel_2 <= '0;
        end else begin
            valid <= pop;
            if (pop) begin
                pixel_1 <= head_1;
                pixel_2 <= head_2;
            end
        end
    end

endmodule : pixel_combine

`default_nettype wire

/* source/pixel_fifo.sv */
`default_nettype none

module pixel_fifo #(
    parameter int DEPTH = aim_bot_pkg::FIFO_DEPTH_DEFAULT
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      wr,
    input  wire aim_bot_pkg::pixel_t wdata,
    input  wire                      rd,
    output aim_bot_pkg::pixel_t      rdata,
    output logic                     empty,
    output logic                     overflow
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

    aim_bot_pkg::pixel_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    // Head entry is always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (wr && full) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule : pixel_fifo

`default_nettype wire

/* source/cam_byte_pack.sv */
`default_nettype none

module cam_byte_pack (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    href,
    input  wire                    strobe,
    input  wire aim_bot_pkg::cam_byte_t data,
    output logic                   href_565,
    output logic                   strobe_565,
    output aim_bot_pkg::pixel_t    data_565
);

    aim_bot_pkg::pack_state_t state;
    aim_bot_pkg::cam_byte_t   high_byte;
    logic                     take;

    // A byte only counts while the line is active
    assign take = strobe && href;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= aim_bot_pkg::PACK_HIGH;
            href_565   <= 1'b0;
            strobe_565 <= 1'b0;
        end else begin
            href_565   <= href;
            strobe_565 <= 1'b0;
            if (!href) begin
                // Line ended, drop any half pixel
                state <= aim_bot_pkg::PACK_HIGH;
            end else if (take) begin
                case (state)
                    aim_bot_pkg::PACK_HIGH: begin
                        state <= aim_bot_pkg::PACK_LOW;
                    end
                    aim_bot_pkg::PACK_LOW: begin
                        state      <= aim_bot_pkg::PACK_HIGH;
                        strobe_565 <= 1'b1;
                    end
                    default: begin
                        state <= aim_bot_pkg::PACK_HIGH;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && state == aim_bot_pkg::PACK_HIGH) begin
            high_byte <= data;
        end
        if (take && state == aim_bot_pkg::PACK_LOW) begin
            data_565 <= {high_byte, data};
        end
    end

endmodule : cam_byte_pack

`default_nettype wire

/* source/aim_bot_pkg.sv */
`default_nettype none

package aim_bot_pkg;

    // One byte as delivered by a camera while href is high
    typedef logic [7:0] cam_byte_t;

    // RGB565 pixel, first received byte in the upper half
    typedef logic [15:0] pixel_t;

    // Byte packer phase
    typedef enum logic {
        PACK_HIGH,
        PACK_LOW
    } pack_state_t;

    // Pixel buffer depth per camera, power of two
    localparam int FIFO_DEPTH_DEFAULT = 16;

    // Paired beats between two heartbeat ticks
    localparam int TICK_DEFAULT = 64;

endpackage : aim_bot_pkg

`default_nettype wire
